// File: design/sys_pkg.sv
// System package: shared widths, host command codes, reset defaults and types
package sys_pkg;

	////////////////////
	// Widths
	localparam int DIM_W      = 12;
	localparam int ASPECT_W   = 8;
	localparam int HOST_W     = 16;
	localparam int CMD_W      = 8;
	localparam int SAMPLE_W   = 16;
	localparam int ATT_W      = 5;
	localparam int MIX_W      = 2;
	localparam int PROD_W     = DIM_W + ASPECT_W;
	localparam int WORD_CNT_W = 4;
	localparam int SYNC_CNT_W = 16;

	// Top attenuation bit mutes, the bits below it shift
	localparam int ATT_MUTE_BIT = ATT_W - 1;

	////////////////////
	// Types
	typedef logic [DIM_W-1:0]           dim_t;
	typedef logic [ASPECT_W-1:0]        aspect_t;
	typedef logic [HOST_W-1:0]          host_word_t;
	typedef logic [CMD_W-1:0]           cmd_t;
	typedef logic [SAMPLE_W-1:0]        sample_t;
	typedef logic signed [SAMPLE_W:0]   wide_sample_t;
	typedef logic [ATT_W-1:0]           att_t;
	typedef logic [MIX_W-1:0]           mix_t;

	typedef enum logic [1:0] {
		S_DECIDE,
		S_DIVIDE,
		S_CLIP,
		S_PLACE
	} win_state_t;

	////////////////////
	// Host commands and word slots
	localparam cmd_t CMD_TIMING = 8'h20;
	localparam cmd_t CMD_VOLUME = 8'h26;
	localparam cmd_t CMD_VSET   = 8'h27;
	localparam cmd_t CMD_FB     = 8'h2F;

	localparam int WORD_WIDTH   = 0;
	localparam int WORD_HEIGHT  = 4;
	localparam int FB_WORD_EN   = 0;
	localparam int FB_WORD_HMIN = 5;
	localparam int FB_WORD_HMAX = 6;
	localparam int FB_WORD_VMIN = 7;
	localparam int FB_WORD_VMAX = 8;
	localparam int FB_EN_BIT    = 15;

	// 1080p frame after reset
	localparam dim_t DEFAULT_WIDTH  = 12'd1920;
	localparam dim_t DEFAULT_HEIGHT = 12'd1080;

	localparam int WIN_PERIOD = 8;

endpackage

// File: design/host_cmd_decoder.sv
// Host command decoder: turns host strobes and data words into configuration registers
`timescale 1ns/1ps

module host_cmd_decoder import sys_pkg::*; (
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic       i_io_uio,
	input  logic       i_io_strobe,
	input  host_word_t i_io_din,
	output dim_t       o_width,
	output dim_t       o_height,
	output dim_t       o_vset,
	output dim_t       o_fb_hmin,
	output dim_t       o_fb_hmax,
	output dim_t       o_fb_vmin,
	output dim_t       o_fb_vmax,
	output logic       o_fb_en,
	output att_t       o_vol_att
);

	logic                  strobe_r;
	logic                  strobe_rr;
	logic                  strobe_edge;
	host_word_t            din_r;
	logic                  has_cmd;
	cmd_t                  cmd;
	logic [WORD_CNT_W-1:0] word_cnt;

	// Data travels alongside the registered strobe
	always_ff @(posedge clk_sys) begin
		din_r <= i_io_din;
	end

	assign strobe_edge = strobe_r & ~strobe_rr;

	////////////////////
	// Command and word tracking
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			strobe_r  <= 1'b0;
			strobe_rr <= 1'b0;
			has_cmd   <= 1'b0;
			cmd       <= '0;
			word_cnt  <= '0;
			o_width   <= DEFAULT_WIDTH;
			o_height  <= DEFAULT_HEIGHT;
			o_vset    <= '0;
			o_fb_en   <= 1'b0;
			o_fb_hmin <= '0;
			o_fb_hmax <= '0;
			o_fb_vmin <= '0;
			o_fb_vmax <= '0;
			o_vol_att <= '0;
		end else begin
			strobe_r  <= i_io_strobe;
			strobe_rr <= strobe_r;
			if (!i_io_uio) begin
				has_cmd  <= 1'b0;
				cmd      <= '0;
				word_cnt <= '0;
			end else if (strobe_edge) begin
				if (!has_cmd) begin
					// First word after select carries the command
					has_cmd  <= 1'b1;
					cmd      <= din_r[CMD_W-1:0];
					word_cnt <= '0;
				end else begin
					// Counter sticks at the top so late words never alias
					if (word_cnt != '1)
						word_cnt <= word_cnt + 1'b1;
					case (cmd)
						CMD_TIMING: begin
							if (word_cnt == WORD_WIDTH)
								o_width <= din_r[DIM_W-1:0];
							if (word_cnt == WORD_HEIGHT)
								o_height <= din_r[DIM_W-1:0];
						end
						CMD_VOLUME: o_vol_att <= din_r[ATT_W-1:0];
						CMD_VSET:   o_vset <= din_r[DIM_W-1:0];
						CMD_FB: begin
							case (word_cnt)
								FB_WORD_EN:   o_fb_en   <= din_r[FB_EN_BIT];
								FB_WORD_HMIN: o_fb_hmin <= din_r[DIM_W-1:0];
								FB_WORD_HMAX: o_fb_hmax <= din_r[DIM_W-1:0];
								FB_WORD_VMIN: o_fb_vmin <= din_r[DIM_W-1:0];
								FB_WORD_VMAX: o_fb_vmax <= din_r[DIM_W-1:0];
								default: ;
							endcase
						end
						default: ;
					endcase
				end
			end
		end
	end

	// The word counter only steps on a data word while the host holds the select
	a_cnt_idle: assert property (@(posedge clk_sys) disable iff (resetd)
		(word_cnt != '0 && word_cnt != $past(word_cnt))
			|-> $past(i_io_uio && strobe_edge && has_cmd))
		else $error("word counter moved without a selected data strobe");

endmodule

// File: design/video_window.sv
// Display window calculator: places the picture inside the output frame
`timescale 1ns/1ps

module video_window import sys_pkg::*; (
	input  logic    clk_sys,
	input  logic    resetd,
	input  dim_t    i_width,
	input  dim_t    i_height,
	input  dim_t    i_vset,
	input  logic    i_fb_en,
	input  dim_t    i_fb_hmin,
	input  dim_t    i_fb_hmax,
	input  dim_t    i_fb_vmin,
	input  dim_t    i_fb_vmax,
	input  aspect_t i_arx,
	input  aspect_t i_ary,
	output dim_t    o_hmin,
	output dim_t    o_hmax,
	output dim_t    o_vmin,
	output dim_t    o_vmax
);

	win_state_t                    state;
	logic [$clog2(WIN_PERIOD)-1:0] step;
	logic [PROD_W-1:0]             prod_w;
	logic [PROD_W-1:0]             prod_h;
	aspect_t                       arx_r;
	aspect_t                       ary_r;
	dim_t                          wcalc;
	dim_t                          hcalc;
	dim_t                          pic_w;
	dim_t                          pic_h;
	dim_t                          v_src;
	dim_t                          h_off;
	dim_t                          v_off;

	// Forced size overrides the frame height
	assign v_src = (i_vset != '0) ? i_vset : i_height;
	assign h_off = (i_width - pic_w) >> 1;
	assign v_off = (i_height - pic_h) >> 1;

	// Products, quotients and clipped picture size
	always_ff @(posedge clk_sys) begin
		case (state)
			S_DECIDE: begin
				prod_w <= v_src * i_arx;
				prod_h <= i_width * i_ary;
				arx_r  <= i_arx;
				ary_r  <= i_ary;
			end
			S_DIVIDE: begin
				// Divider gets the whole divide phase to settle
				wcalc <= dim_t'(prod_w / ary_r);
				hcalc <= dim_t'(prod_h / arx_r);
			end
			S_CLIP: begin
				pic_w <= (i_vset == '0 && wcalc > i_width) ? i_width : wcalc;
				pic_h <= (i_vset != '0) ? i_vset : (hcalc > i_height) ? i_height : hcalc;
			end
			default: ;
		endcase
	end

	////////////////////
	// Sequencer and window outputs
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state  <= S_DECIDE;
			step   <= '0;
			o_hmin <= '0;
			o_hmax <= '0;
			o_vmin <= '0;
			o_vmax <= '0;
		end else begin
			case (state)
				S_DECIDE: begin
					if (i_fb_en) begin
						o_hmin <= i_fb_hmin;
						o_hmax <= i_fb_hmax;
						o_vmin <= i_fb_vmin;
						o_vmax <= i_fb_vmax;
					end else if (i_arx != '0 && i_ary != '0) begin
						state <= S_DIVIDE;
						step  <= 1'b1;
					end else begin
						o_hmin <= '0;
						o_hmax <= i_width - 1'b1;
						o_vmin <= '0;
						o_vmax <= i_height - 1'b1;
					end
				end
				S_DIVIDE: begin
					step <= step + 1'b1;
					if (step == WIN_PERIOD - 3)
						state <= S_CLIP;
				end
				S_CLIP: state <= S_PLACE;
				S_PLACE: begin
					o_hmin <= h_off;
					o_hmax <= h_off + pic_w - 1'b1;
					o_vmin <= v_off;
					o_vmax <= v_off + pic_h - 1'b1;
					state  <= S_DECIDE;
				end
				default: state <= S_DECIDE;
			endcase
		end
	end

	// A picture that fits the frame gives an ordered horizontal window
	a_win_order: assert property (@(posedge clk_sys) disable iff (resetd)
		(state == S_PLACE && pic_w != '0 && pic_w <= i_width) |=> o_hmin <= o_hmax)
		else $error("window hmin above hmax");

endmodule

// File: design/audio_mixer.sv
// Audio mixer channel: glitch filter, PCM sum, cross-feed, attenuation and clamp
`timescale 1ns/1ps

module audio_mixer import sys_pkg::*; (
	input  logic    clk_sys,
	input  logic    resetd,
	input  sample_t i_core,
	input  sample_t i_pcm,
	input  sample_t i_pre_in,
	input  logic    i_signed,
	input  mix_t    i_mix,
	input  att_t    i_att,
	output sample_t o_pre_out,
	output sample_t o_out
);

	sample_t      dly1;
	sample_t      dly2;
	sample_t      dly3;
	sample_t      core_s;
	wide_sample_t pcm_ext;
	wide_sample_t pre_ext;
	wide_sample_t a1;
	wide_sample_t a2;
	wide_sample_t a3;
	wide_sample_t a4;

	assign pcm_ext   = {i_pcm[SAMPLE_W-1], i_pcm};
	assign pre_ext   = {i_pre_in[SAMPLE_W-1], i_pre_in};
	assign o_pre_out = a2[SAMPLE_W:1];

	// Three stage delay for the core sample
	always_ff @(posedge clk_sys) begin
		dly1 <= i_core;
		dly2 <= dly1;
		dly3 <= dly2;
	end

	////////////////////
	// Filter and mix pipeline
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			core_s <= '0;
			a1     <= '0;
			a2     <= '0;
			a3     <= '0;
			a4     <= '0;
			o_out  <= '0;
		end else begin
			// Only a value seen twice in a row gets through
			if (dly2 == dly3)
				core_s <= dly2;
			a1 <= i_signed ? {core_s[SAMPLE_W-1], core_s} : {2'b00, core_s[SAMPLE_W-1:1]};
			a2 <= a1 + pcm_ext;
			case (i_mix)
				2'd0: a3 <= a2;
				2'd1: a3 <= a2 - (a2 >>> 3) + (pre_ext >>> 2);
				2'd2: a3 <= a2 - (a2 >>> 2) + (pre_ext >>> 1);
				default: a3 <= (a2 >>> 1) + pre_ext;
			endcase
			if (i_att[ATT_MUTE_BIT])
				a4 <= '0;
			else
				a4 <= a3 >>> i_att[ATT_MUTE_BIT-1:0];
			// Saturate to the signed 16-bit range
			if (a4[SAMPLE_W] != a4[SAMPLE_W-1])
				o_out <= {a4[SAMPLE_W], {(SAMPLE_W-1){a4[SAMPLE_W-1]}}};
			else
				o_out <= a4[SAMPLE_W-1:0];
		end
	end

	a_mute: assert property (@(posedge clk_sys) disable iff (resetd)
		(i_att[ATT_MUTE_BIT] && $past(i_att[ATT_MUTE_BIT])) |=> o_out == '0)
		else $error("output not silent while muted");

endmodule

// File: design/sync_polarity.sv
// Sync polarity normaliser: measures both phases and drives the sync active high
`timescale 1ns/1ps

module sync_polarity import sys_pkg::*; (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                  sync_r;
	logic                  sync_rr;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] hi_time;
	logic [SYNC_CNT_W-1:0] lo_time;
	logic                  pol;

	// Longer phase is the inactive one
	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			sync_r  <= 1'b0;
			sync_rr <= 1'b0;
			cnt     <= '0;
			hi_time <= '0;
			lo_time <= '0;
			pol     <= 1'b0;
		end else begin
			sync_r  <= i_sync;
			sync_rr <= sync_r;
			if (sync_rr & ~sync_r)
				hi_time <= cnt;
			if (~sync_rr & sync_r)
				lo_time <= cnt;
			if (sync_rr != sync_r)
				cnt <= '0;
			else if (cnt != '1)
				cnt <= cnt + 1'b1;
			pol <= hi_time > lo_time;
		end
	end

endmodule

// File: design/sys_core.sv
// HAL core top: host decoder, window calculator, stereo mixer and sync normalisers
`timescale 1ns/1ps

module sys_core import sys_pkg::*; (
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic       i_io_uio,
	input  logic       i_io_strobe,
	input  host_word_t i_io_din,
	input  aspect_t    i_arx,
	input  aspect_t    i_ary,
	input  sample_t    i_core_l,
	input  sample_t    i_core_r,
	input  sample_t    i_pcm_l,
	input  sample_t    i_pcm_r,
	input  logic       i_audio_signed,
	input  mix_t       i_audio_mix,
	input  logic       i_hs,
	input  logic       i_vs,
	output dim_t       o_hmin,
	output dim_t       o_hmax,
	output dim_t       o_vmin,
	output dim_t       o_vmax,
	output sample_t    o_audio_l,
	output sample_t    o_audio_r,
	output logic       o_hs,
	output logic       o_vs
);

	dim_t    width;
	dim_t    height;
	dim_t    vset;
	dim_t    fb_hmin;
	dim_t    fb_hmax;
	dim_t    fb_vmin;
	dim_t    fb_vmax;
	logic    fb_en;
	att_t    vol_att;
	sample_t pre_l;
	sample_t pre_r;

	////////////////////
	// Host configuration
	host_cmd_decoder u_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_width     (width),
		.o_height    (height),
		.o_vset      (vset),
		.o_fb_hmin   (fb_hmin),
		.o_fb_hmax   (fb_hmax),
		.o_fb_vmin   (fb_vmin),
		.o_fb_vmax   (fb_vmax),
		.o_fb_en     (fb_en),
		.o_vol_att   (vol_att)
	);

	video_window u_window (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_width   (width),
		.i_height  (height),
		.i_vset    (vset),
		.i_fb_en   (fb_en),
		.i_fb_hmin (fb_hmin),
		.i_fb_hmax (fb_hmax),
		.i_fb_vmin (fb_vmin),
		.i_fb_vmax (fb_vmax),
		.i_arx     (i_arx),
		.i_ary     (i_ary),
		.o_hmin    (o_hmin),
		.o_hmax    (o_hmax),
		.o_vmin    (o_vmin),
		.o_vmax    (o_vmax)
	);

	////////////////////
	// Stereo mix, each side feeds the other its pre-mix value
	audio_mixer u_mix_l (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_core    (i_core_l),
		.i_pcm     (i_pcm_l),
		.i_pre_in  (pre_r),
		.i_signed  (i_audio_signed),
		.i_mix     (i_audio_mix),
		.i_att     (vol_att),
		.o_pre_out (pre_l),
		.o_out     (o_audio_l)
	);

	audio_mixer u_mix_r (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_core    (i_core_r),
		.i_pcm     (i_pcm_r),
		.i_pre_in  (pre_l),
		.i_signed  (i_audio_signed),
		.i_mix     (i_audio_mix),
		.i_att     (vol_att),
		.o_pre_out (pre_r),
		.o_out     (o_audio_r)
	);

	sync_polarity u_sync_h (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs),
		.o_sync  (o_hs)
	);

	sync_polarity u_sync_v (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs),
		.o_sync  (o_vs)
	);

endmodule

// File: tests/tb_model.svh
// Testbench reference model: expected display window, mixer output and value check
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Expected window when the framebuffer is off
task automatic model_window(input dim_t w, input dim_t h, input dim_t vs,
		input aspect_t ax, input aspect_t ay, output dim_t e_hmin, output dim_t e_hmax,
		output dim_t e_vmin, output dim_t e_vmax);
	int   src;
	int   prod;
	dim_t wc;
	dim_t hc;
	dim_t pw;
	dim_t ph;
	dim_t diff;
	if (ax == 0 || ay == 0) begin
		e_hmin = '0;
		e_hmax = w - 1;
		e_vmin = '0;
		e_vmax = h - 1;
	end else begin
		src  = (vs != 0) ? int'(vs) : int'(h);
		prod = src * int'(ax);
		wc   = dim_t'(prod / int'(ay));
		prod = int'(w) * int'(ay);
		hc   = dim_t'(prod / int'(ax));
		pw   = (vs == 0 && wc > w) ? w : wc;
		if (vs != 0)
			ph = vs;
		else
			ph = (hc < h) ? hc : h;
		// Centre the picture, odd leftovers go to the far side
		diff   = w - pw;
		e_hmin = diff >> 1;
		e_hmax = e_hmin + pw - 1;
		diff   = h - ph;
		e_vmin = diff >> 1;
		e_vmax = e_vmin + ph - 1;
	end
endtask

// Core plus PCM before the cross-feed
function automatic wide_sample_t sum_stage(input sample_t core, input sample_t pcm,
		input logic sgn);
	int c;
	int p;
	if (sgn)
		c = int'($signed(core));
	else
		c = int'(core) / 2;
	p = int'($signed(pcm));
	return wide_sample_t'(c + p);
endfunction

// Cross-feed, attenuation and saturation of one channel
function automatic sample_t mix_stage(input wide_sample_t a2, input sample_t pre,
		input mix_t mode, input att_t att);
	int a;
	int x;
	int mixed;
	int shifted;
	a = int'(a2);
	x = int'($signed(pre));
	case (mode)
		2'd0:    mixed = a;
		2'd1:    mixed = a - (a >>> 3) + (x >>> 2);
		2'd2:    mixed = a - (a >>> 2) + (x >>> 1);
		default: mixed = (a >>> 1) + x;
	endcase
	mixed = int'(wide_sample_t'(mixed));
	if (att[4])
		shifted = 0;
	else
		shifted = mixed >>> att[3:0];
	if (shifted > 32767)
		return 16'h7fff;
	else if (shifted < -32768)
		return 16'h8000;
	else
		return sample_t'(shifted);
endfunction

task automatic check_value(input string name, input logic [31:0] exp_v,
		input logic [31:0] act_v);
	if (exp_v !== act_v) begin
		err_cnt = err_cnt + 1;
		$display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
		fail_run("an output differed from the reference model");
	end
endtask

`endif

// File: tests/tb_sys_core.sv
// Testbench for the HAL core: host commands, window, stereo mixer and sync checks
`timescale 1ns/1ps

module tb_sys_core import sys_pkg::*; ();

	localparam logic [31:0] SEED = 32'h4d9a1e28;
	localparam int N_WIN       = 30;
	localparam int N_FB        = 4;
	localparam int N_MIX       = 30;
	localparam int N_SYNC      = 6;
	localparam int ITEM_CYCLES = 400;
	localparam int TIMEOUT_CYCLES = (N_WIN + N_FB + N_MIX + N_SYNC) * ITEM_CYCLES + 500;

	logic       clk_sys = 1'b0;
	logic       resetd;
	logic       io_uio;
	logic       io_strobe;
	host_word_t io_din;
	aspect_t    arx;
	aspect_t    ary;
	sample_t    core_l;
	sample_t    core_r;
	sample_t    pcm_l;
	sample_t    pcm_r;
	logic       audio_signed;
	mix_t       audio_mix;
	logic       hs;
	logic       vs;
	dim_t       hmin;
	dim_t       hmax;
	dim_t       vmin;
	dim_t       vmax;
	sample_t    audio_l;
	sample_t    audio_r;
	logic       hs_out;
	logic       vs_out;

	// Configuration the host has written so far
	dim_t       m_width;
	dim_t       m_height;
	dim_t       m_vset;
	host_word_t words [0:15];
	int         err_cnt = 0;

	`include "tb_model.svh"

	always #2 clk_sys = ~clk_sys;

	sys_core i_dut (
		.clk_sys        (clk_sys),
		.resetd         (resetd),
		.i_io_uio       (io_uio),
		.i_io_strobe    (io_strobe),
		.i_io_din       (io_din),
		.i_arx          (arx),
		.i_ary          (ary),
		.i_core_l       (core_l),
		.i_core_r       (core_r),
		.i_pcm_l        (pcm_l),
		.i_pcm_r        (pcm_r),
		.i_audio_signed (audio_signed),
		.i_audio_mix    (audio_mix),
		.i_hs           (hs),
		.i_vs           (vs),
		.o_hmin         (hmin),
		.o_hmax         (hmax),
		.o_vmin         (vmin),
		.o_vmax         (vmax),
		.o_audio_l      (audio_l),
		.o_audio_r      (audio_r),
		.o_hs           (hs_out),
		.o_vs           (vs_out)
	);

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "simulation stopped on error");
	endtask

	// Lands just after the rising edge, where inputs change
	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	////////////////////
	// Host bus
	task automatic send_word(input host_word_t w);
		io_din    = w;
		io_strobe = 1'b1;
		wait_cycles(2);
		io_strobe = 1'b0;
		wait_cycles(2);
	endtask

	task automatic send_cmd(input cmd_t c, input int n);
		int i;
		io_uio = 1'b1;
		next_cycle();
		send_word({8'($urandom), c});
		for (i = 0; i < n; i++)
			send_word(words[i]);
		wait_cycles(2);
		io_uio = 1'b0;
		wait_cycles(2);
	endtask

	task automatic set_timing(input dim_t w, input dim_t h);
		int i;
		for (i = 0; i < 8; i++)
			words[i] = 16'($urandom);
		words[WORD_WIDTH]  = {4'($urandom), w};
		words[WORD_HEIGHT] = {4'($urandom), h};
		send_cmd(CMD_TIMING, 5 + $urandom % 3);
		m_width  = w;
		m_height = h;
	endtask

	task automatic set_vset(input dim_t v);
		words[0] = {4'($urandom), v};
		send_cmd(CMD_VSET, 1);
		m_vset = v;
	endtask

	task automatic set_volume(input att_t a);
		words[0] = {11'($urandom), a};
		send_cmd(CMD_VOLUME, 1);
	endtask

	task automatic set_fb(input logic en, input dim_t h0, input dim_t h1,
			input dim_t v0, input dim_t v1);
		int i;
		for (i = 0; i < 9; i++)
			words[i] = 16'($urandom);
		words[FB_WORD_EN][FB_EN_BIT] = en;
		words[FB_WORD_HMIN] = {4'($urandom), h0};
		words[FB_WORD_HMAX] = {4'($urandom), h1};
		words[FB_WORD_VMIN] = {4'($urandom), v0};
		words[FB_WORD_VMAX] = {4'($urandom), v1};
		send_cmd(CMD_FB, en ? 9 : 1);
	endtask

	// Traffic the decoder must ignore
	task automatic noise_traffic();
		cmd_t c;
		int   i;
		c = 8'($urandom);
		if (c == CMD_TIMING || c == CMD_VOLUME || c == CMD_VSET || c == CMD_FB)
			c = 8'h21;
		for (i = 0; i < 11; i++)
			words[i] = 16'($urandom);
		send_cmd(c, 1 + $urandom % 10);
		for (i = 0; i < 3; i++)
			send_word(16'($urandom));
	endtask

	task automatic check_window(input string tag);
		dim_t e_hmin;
		dim_t e_hmax;
		dim_t e_vmin;
		dim_t e_vmax;
		model_window(m_width, m_height, m_vset, arx, ary, e_hmin, e_hmax, e_vmin, e_vmax);
		check_value({tag, "_hmin"}, e_hmin, hmin);
		check_value({tag, "_hmax"}, e_hmax, hmax);
		check_value({tag, "_vmin"}, e_vmin, vmin);
		check_value({tag, "_vmax"}, e_vmax, vmax);
	endtask

	////////////////////
	// Test groups
	task automatic run_window_tests();
		int k;
		int v;
		int lim;
		for (k = 0; k < N_WIN; k++) begin
			arx = 8'(1 + $urandom % 16);
			ary = 8'(1 + $urandom % 16);
			if ($urandom % 6 == 0)
				arx = '0;
			if ($urandom % 4 != 0)
				set_timing(dim_t'(640 + $urandom % 1400), dim_t'(360 + $urandom % 840));
			noise_traffic();
			if ($urandom % 3 == 0 || arx == 0) begin
				v = 0;
			end else begin
				// Forced size fits the height and, scaled, the width
				v   = int'(m_height) / 2 + $urandom % (int'(m_height) / 2 + 1);
				lim = (int'(m_width) * int'(ary)) / int'(arx);
				if (v > lim)
					v = lim;
			end
			set_vset(dim_t'(v));
			wait_cycles(24);
			check_window("win");
		end
	endtask

	task automatic run_fb_tests();
		int   k;
		dim_t h0;
		dim_t h1;
		dim_t v0;
		dim_t v1;
		for (k = 0; k < N_FB; k++) begin
			h0 = dim_t'($urandom);
			h1 = dim_t'($urandom);
			v0 = dim_t'($urandom);
			v1 = dim_t'($urandom);
			set_fb(1'b1, h0, h1, v0, v1);
			wait_cycles(20);
			check_value("fb_hmin", h0, hmin);
			check_value("fb_hmax", h1, hmax);
			check_value("fb_vmin", v0, vmin);
			check_value("fb_vmax", v1, vmax);
			set_fb(1'b0, h0, h1, v0, v1);
			wait_cycles(24);
			check_window("fb_off");
		end
	endtask

	task automatic run_mixer_tests();
		int           k;
		int           i;
		att_t         att;
		sample_t      keep;
		wide_sample_t a2_l;
		wide_sample_t a2_r;
		sample_t      exp_l;
		sample_t      exp_r;
		for (k = 0; k < N_MIX; k++) begin
			att = 5'($urandom);
			if ($urandom % 2)
				att[4] = 1'b0;
			set_volume(att);
			core_l       = 16'($urandom);
			core_r       = 16'($urandom);
			pcm_l        = 16'($urandom);
			pcm_r        = 16'($urandom);
			audio_signed = 1'($urandom);
			audio_mix    = 2'($urandom);
			wait_cycles(10);
			a2_l  = sum_stage(core_l, pcm_l, audio_signed);
			a2_r  = sum_stage(core_r, pcm_r, audio_signed);
			exp_l = mix_stage(a2_l, a2_r[16:1], audio_mix, att);
			exp_r = mix_stage(a2_r, a2_l[16:1], audio_mix, att);
			check_value("mix_l", exp_l, audio_l);
			check_value("mix_r", exp_r, audio_r);
			// Single cycle spike on the left core sample
			keep   = core_l;
			core_l = ~keep;
			next_cycle();
			core_l = keep;
			for (i = 0; i < 12; i++) begin
				next_cycle();
				check_value("glitch_l", exp_l, audio_l);
				check_value("glitch_r", exp_r, audio_r);
			end
		end
	endtask

	task automatic run_sync_tests();
		int   k;
		int   cyc;
		int   total;
		int   h_act;
		int   h_per;
		int   v_act;
		int   v_per;
		logic h_pol;
		logic v_pol;
		logic h_on;
		logic v_on;
		for (k = 0; k < N_SYNC; k++) begin
			h_act = 2 + $urandom % 20;
			h_per = 2 * h_act + 1 + $urandom % 30;
			v_act = 2 + $urandom % 20;
			v_per = 2 * v_act + 1 + $urandom % 30;
			h_pol = 1'($urandom);
			v_pol = 1'($urandom);
			total = 4 * ((h_per > v_per) ? h_per : v_per);
			for (cyc = 0; cyc < total; cyc++) begin
				h_on = (cyc % h_per) < h_act;
				v_on = (cyc % v_per) < v_act;
				hs   = h_pol ? h_on : ~h_on;
				vs   = v_pol ? v_on : ~v_on;
				#1;
				if (cyc >= 3 * h_per)
					check_value("sync_hs", h_on, hs_out);
				if (cyc >= 3 * v_per)
					check_value("sync_vs", v_on, vs_out);
				next_cycle();
			end
		end
	endtask

	////////////////////
	// Main sequence
	initial begin
		void'($urandom(SEED));
		resetd       = 1'b1;
		io_uio       = 1'b0;
		io_strobe    = 1'b0;
		io_din       = '0;
		arx          = '0;
		ary          = '0;
		core_l       = '0;
		core_r       = '0;
		pcm_l        = '0;
		pcm_r        = '0;
		audio_signed = 1'b0;
		audio_mix    = '0;
		hs           = 1'b0;
		vs           = 1'b0;
		m_width      = DEFAULT_WIDTH;
		m_height     = DEFAULT_HEIGHT;
		m_vset       = '0;
		repeat (2) @(posedge clk_sys);
		#1 resetd = 1'b0;
		check_value("reset_audio_l", 0, audio_l);
		check_value("reset_audio_r", 0, audio_r);
		wait_cycles(16);
		check_value("reset_hmin", 0, hmin);
		check_value("reset_hmax", 1919, hmax);
		check_value("reset_vmin", 0, vmin);
		check_value("reset_vmax", 1079, vmax);
		check_value("idle_audio_l", 0, audio_l);
		check_value("idle_audio_r", 0, audio_r);
		run_window_tests();
		run_fb_tests();
		run_mixer_tests();
		run_sync_tests();
		if (err_cnt == 0) begin
			$display("TESTBENCH PASSED");
			$finish;
		end else begin
			fail_run("errors were recorded during the run");
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk_sys);
		fail_run("watchdog expired before the tests completed");
	end

endmodule

// File: compile.f
+incdir+tests
design/sys_pkg.sv
design/host_cmd_decoder.sv
design/video_window.sv
design/audio_mixer.sv
design/sync_polarity.sv
design/sys_core.sv
tests/tb_sys_core.sv

// File: Bender.yml
package:
  name: sys_core

sources:
  - design/sys_pkg.sv
  - design/host_cmd_decoder.sv
  - design/video_window.sv
  - design/audio_mixer.sv
  - design/sync_polarity.sv
  - design/sys_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_sys_core.sv
